// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - files:
      - hdl/mem_pkg.sv
      - hdl/mem_bus_if.sv
      - hdl/data_ram.sv
      - hdl/io_unit.sv
      - hdl/data_mem.sv
      - hdl/mem_stage_top.sv
  - target: test
    files:
      - dv/mem_stage_tb.sv

// ==== dv/mem_stage_tb.sv ====
`default_nettype none

module mem_stage_tb;
    import mem_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int WAIT_LIMIT   = 50;                          // cycles before giving up on DUT
    localparam int RESET_CYCLES = 8;
    localparam int SWEEP_N      = 200;
    // reset, then each test in run order, sweep ops take at most 3 cycles
    localparam int EST_CYCLES   = RESET_CYCLES + 5 + 7 + 10 + 16 + 18 + SWEEP_N * 3;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_write;
    logic [ADDR_W-1:0]      req_addr;
    logic [DATA_W-1:0]      req_wdata;
    logic                   stall;
    logic                   rsp_valid;
    logic [DATA_W-1:0]      rsp_data;
    logic                   key_request;
    logic                   key_valid;
    logic [DATA_W-1:0]      key_data;
    logic [DATA_W-1:0]      vga_value;
    logic                   vga_update;
    logic                   load_mode;
    logic                   load_we;
    logic [LOAD_ADDR_W-1:0] load_addr;
    logic [DATA_W-1:0]      load_data;

    logic [DATA_W-1:0] model [RAM_DEPTH];   // expected RAM contents
    int                errors = 0;
    int                tests  = 0;
    logic              rsp_first;           // rsp_valid one cycle after accept
    logic [DATA_W-1:0] rsp_first_data;

    mem_stage_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hang guard
    initial begin
        #(EST_CYCLES * 2 * CLK_PERIOD);
        $display("watchdog expired, the tests did not complete in time");
        $display("TEST FAILED");
        $finish;
    end

    function automatic int unsigned word_index(input logic [ADDR_W-1:0] addr);
        return addr[15:2];                     // upper bits alias
    endfunction

    task automatic compare(input string name, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // one-cycle request that returns at the negedge after acceptance
    task automatic issue(input logic wr, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wd);
        @(negedge clk);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wd;
        @(negedge clk);
        rsp_first      = rsp_valid;            // sampled before the drop
        rsp_first_data = rsp_data;
        req_valid      = 1'b0;
    endtask

    task automatic wait_idle(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (stall && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (stall) begin
            $display("%s: stall stayed high after the access", name);
            errors++;
        end
    endtask

    task automatic wait_response(input string name, output logic [DATA_W-1:0] data,
                                 output int lat);
        logic got;
        got  = rsp_first;
        data = rsp_first_data;
        lat  = 1;
        while (!got && lat < WAIT_LIMIT) begin
            @(negedge clk);
            lat++;
            got  = rsp_valid;
            data = rsp_data;
        end
        if (!got) begin
            $display("%s: no read response within %0d cycles", name, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic ram_write(input string name, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
        issue(1'b1, addr, data);
        if (rsp_first) begin
            $display("%s: a store produced a read response", name);
            errors++;
        end
        wait_idle(name);
        model[word_index(addr)] = data;
    endtask

    task automatic check_read(input string name, input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] rd;
        int                lat;
        issue(1'b0, addr, '0);
        wait_response(name, rd, lat);
        compare(name, model[word_index(addr)], rd);
    endtask

    task automatic end_test(input string name, input int start_err);
        tests++;
        $display("test %s finished with %0d errors", name, errors - start_err);
    endtask

    task automatic reset_and_first_read();
        int                start_err;
        logic [DATA_W-1:0] rd;
        int                lat;
        start_err = errors;
        compare("reset_state", 0, stall);
        compare("reset_state", 0, rsp_valid);
        compare("reset_state", 0, key_request);
        compare("reset_state", 0, vga_update);
        compare("reset_state", 0, vga_value);
        ram_write("reset_state", 32'h0000_0040, 32'hA5A5_0F0F);
        issue(1'b0, 32'h0000_0040, '0);
        wait_response("reset_state", rd, lat);
        compare("reset_state", 1, lat);               // rsp in N+1
        compare("reset_state", 32'hA5A5_0F0F, rd);
        end_test("reset_state", start_err);
    endtask

    task automatic store_load_alias();
        int          start_err;
        int unsigned idx;
        logic [31:0] hi;
        start_err = errors;
        idx = $urandom % RAM_DEPTH;
        hi  = $urandom & 32'h7FFF_0000;               // bit 31 clear keeps it out of IO
        ram_write("store_load", hi | (idx << 2), $urandom);
        check_read("store_load", hi | (idx << 2));
        check_read("store_load", (hi ^ 32'h0123_0000) | (idx << 2));  // alias
        end_test("store_load", start_err);
    endtask

    task automatic vga_store();
        int          start_err;
        int          pulses;
        logic [31:0] val;
        start_err = errors;
        val = $urandom;
        ram_write("vga", 32'h0000_FC70, 32'h1357_9BDF);   // same word index as the VGA port
        @(negedge clk);
        req_valid = 1'b1;
        req_write = 1'b1;
        req_addr  = 32'hFFFF_FC70;
        req_wdata = val;
        pulses    = 0;
        repeat (4) begin
            @(negedge clk);
            if (vga_update) pulses++;
            req_valid = 1'b0;
        end
        compare("vga", 1, pulses);
        compare("vga", val, vga_value);
        compare("vga", 0, stall);
        check_read("vga", 32'h0000_FC70);             // RAM word untouched
        end_test("vga", start_err);
    endtask

    task automatic keypad_load();
        int          start_err;
        int          wait_n;
        logic [31:0] kval;
        start_err = errors;
        wait_n = 1 + ($urandom % 12);
        kval   = $urandom;
        issue(1'b0, 32'hFFFF_FC60, '0);
        compare("keypad", 0, rsp_first);
        compare("keypad", 1, key_request);            // raised from N+1
        compare("keypad", 1, stall);
        for (int i = 0; i < wait_n; i++) begin
            @(negedge clk);
            compare("keypad", 1, key_request);
            compare("keypad", 1, stall);
            compare("keypad", 0, rsp_valid);
        end
        key_valid = 1'b1;                             // user enters a value
        key_data  = kval;
        @(negedge clk);
        compare("keypad", 1, rsp_valid);              // ack the cycle after
        compare("keypad", kval, rsp_data);
        key_valid = 1'b0;
        key_data  = '0;
        @(negedge clk);
        compare("keypad", 0, key_request);
        compare("keypad", 0, stall);
        end_test("keypad", start_err);
    endtask

    task automatic loader_writes();
        int start_err;
        start_err = errors;
        ram_write("loader", 32'h0000_0100, 32'h1111_1111);  // target of ignored pipeline write
        ram_write("loader", 32'h0000_0108, 32'h3333_3333);  // target of instruction word
        @(negedge clk);
        load_mode = 1'b1;
        @(negedge clk);
        compare("loader", 1, stall);
        req_valid = 1'b1;                                   // should be ignored
        req_write = 1'b1;
        req_addr  = 32'h0000_0100;
        req_wdata = 32'hDEAD_BEEF;
        @(negedge clk);
        compare("loader", 1, stall);
        req_valid = 1'b0;
        load_we   = 1'b1;
        load_addr = {1'b1, 14'(32'h104 >> 2)};              // data word
        load_data = 32'h2222_2222;
        @(negedge clk);
        load_addr = {1'b0, 14'(32'h108 >> 2)};              // instruction word
        load_data = 32'h4444_4444;
        @(negedge clk);
        load_we = 1'b0;
        @(negedge clk);
        load_mode = 1'b0;
        model[word_index(32'h104)] = 32'h2222_2222;
        check_read("loader", 32'h0000_0100);
        check_read("loader", 32'h0000_0104);
        check_read("loader", 32'h0000_0108);
        end_test("loader", start_err);
    endtask

    task automatic random_sweep();
        int          start_err;
        int unsigned idx_q[$];
        int unsigned idx;
        logic [31:0] hi;
        start_err = errors;
        for (int i = 0; i < SWEEP_N; i++) begin
            hi = $urandom & 32'h7FFF_0000;
            if (idx_q.size() == 0 || ($urandom % 2) == 0) begin
                idx = $urandom % RAM_DEPTH;
                ram_write("sweep", hi | (idx << 2), $urandom);
                idx_q.push_back(idx);
            end else begin
                idx = idx_q[$urandom % idx_q.size()];  // only words with a known value
                check_read("sweep", hi | (idx << 2));
            end
        end
        end_test("sweep", start_err);
    endtask

    initial begin
        void'($urandom(32'h94c826ef));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        key_valid = 1'b0;
        key_data  = '0;
        load_mode = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        reset_and_first_read();
        store_load_alias();
        vga_store();
        keypad_load();
        loader_writes();
        random_sweep();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/mem_pkg.sv
hdl/mem_bus_if.sv
hdl/data_ram.sv
hdl/io_unit.sv
hdl/data_mem.sv
hdl/mem_stage_top.sv
dv/mem_stage_tb.sv

// ==== hdl/data_mem.sv ====
`default_nettype none

module data_mem (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_mode,   // loader active, pipeline held
    input  logic                        req_valid,
    input  logic                        req_write,
    input  logic [mem_pkg::ADDR_W-1:0]  req_addr,
    input  logic [mem_pkg::DATA_W-1:0]  req_wdata,
    output logic                        stall,       // back-pressure to pipeline
    output logic                        rsp_valid,   // load result strobe
    output logic [mem_pkg::DATA_W-1:0]  rsp_data,
    mem_bus_if.master                   ram_bus,
    mem_bus_if.master                   io_bus
);
    import mem_pkg::*;

    logic req_io;      // request targets the IO page
    logic accept;      // request taken this cycle
    logic ack;         // either slave finished
    logic busy;        // one access outstanding
    logic busy_write;  // outstanding access is a store

    assign req_io = is_io_addr(req_addr);
    assign ack    = ram_bus.ack | io_bus.ack;

    // a new request may ride on the ack cycle of the previous one
    assign accept = req_valid & ~load_mode & (~busy | ack);

    // steer to exactly one slave
    assign ram_bus.valid = accept & ~req_io;
    assign ram_bus.write = req_write;
    assign ram_bus.addr  = req_addr;
    assign ram_bus.wdata = req_wdata;

    assign io_bus.valid  = accept & req_io;
    assign io_bus.write  = req_write;
    assign io_bus.addr   = req_addr;
    assign io_bus.wdata  = req_wdata;

    // outstanding tracker
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            busy_write <= 1'b0;
        end else if (accept) begin
            busy       <= 1'b1;
            busy_write <= req_write;
        end else if (ack) begin
            busy       <= 1'b0;
        end
    end

    // stall drops in the ack cycle unless something new shows up
    assign stall = load_mode | req_valid | (busy & ~ack);

    // stores complete silently
    assign rsp_valid = ack & ~busy_write;
    assign rsp_data  = io_bus.ack ? io_bus.rdata : ram_bus.rdata;

endmodule

`default_nettype wire

// ==== hdl/data_ram.sv ====
`default_nettype none

module data_ram (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             load_mode,  // loader owns the array
    input  logic                             load_we,    // loader word strobe
    input  logic [mem_pkg::LOAD_ADDR_W-1:0]  load_addr,  // msb selects data memory
    input  logic [mem_pkg::DATA_W-1:0]       load_data,
    mem_bus_if.slave                         bus
);
    import mem_pkg::*;

    logic [DATA_W-1:0]    mem [RAM_DEPTH];   // 16K x 32 array
    logic [RAM_IDX_W-1:0] bus_idx;           // word index from pipeline address
    logic                 load_sel;          // loader word is for data memory
    logic                 wr_en;
    logic [RAM_IDX_W-1:0] wr_idx;
    logic [DATA_W-1:0]    wr_data;

    assign bus_idx  = bus.addr[RAM_IDX_W+WORD_LSB-1:WORD_LSB];  // upper bits alias
    assign load_sel = load_addr[LOAD_ADDR_W-1];

    // single write port, loader wins while load mode is on
    always_comb begin
        if (load_mode) begin
            wr_en   = load_we & load_sel;                   // instruction words dropped
            wr_idx  = load_addr[RAM_IDX_W-1:0];
            wr_data = load_data;
        end else begin
            wr_en   = bus.valid & bus.write;
            wr_idx  = bus_idx;
            wr_data = bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read, lands with the ack
    always_ff @(posedge clk) begin
        if (bus.valid && !bus.write) begin
            bus.rdata <= mem[bus_idx];
        end
    end

    // every access completes one cycle after valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.valid;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/io_unit.sv ====
`default_nettype none

module io_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        key_valid,    // user has entered a value
    input  logic [mem_pkg::DATA_W-1:0]  key_data,     // keypad value
    output logic                        key_request,  // ask keypad for input
    output logic [mem_pkg::DATA_W-1:0]  vga_value,    // display register
    output logic                        vga_update,   // display register loaded
    mem_bus_if.slave                    bus
);
    import mem_pkg::*;

    typedef enum logic {
        IO_IDLE,
        IO_KEY_WAIT
    } io_state_t;

    io_state_t state;
    logic      key_sel;    // keypad addressed, else vga
    logic      key_read;   // keypad load starts a wait
    logic      key_done;   // wait ends this cycle

    assign key_sel     = ~bus.addr[IO_TYPE_BIT];
    assign key_read    = bus.valid & key_sel & ~bus.write;
    assign key_done    = (state == IO_KEY_WAIT) & key_valid;
    assign key_request = (state == IO_KEY_WAIT);   // held until key_valid sampled

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IO_IDLE;
            bus.ack    <= 1'b0;
            vga_update <= 1'b0;
            vga_value  <= '0;
        end else begin
            bus.ack    <= 1'b0;            // pulses by default
            vga_update <= 1'b0;
            case (state)
                IO_IDLE: begin
                    if (key_read) begin
                        state <= IO_KEY_WAIT;   // latency set by user
                    end else if (bus.valid) begin
                        bus.ack <= 1'b1;        // everything else done in one cycle
                        if (!key_sel && bus.write) begin
                            vga_value  <= bus.wdata;
                            vga_update <= 1'b1;  // same cycle as ack
                        end
                    end
                end
                IO_KEY_WAIT: begin
                    if (key_valid) begin
                        state   <= IO_IDLE;
                        bus.ack <= 1'b1;        // cycle after key_valid
                    end
                end
                default: state <= IO_IDLE;
            endcase
        end
    end

    // read data, keypad capture or zero for the odd accesses
    always_ff @(posedge clk) begin
        if (key_done) begin
            bus.rdata <= key_data;
        end else if (state == IO_IDLE && bus.valid) begin
            bus.rdata <= '0;               // vga read, keypad write
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_bus_if.sv ====
`default_nettype none

interface mem_bus_if;
    import mem_pkg::*;

    logic              valid;   // one-cycle request strobe
    logic              write;   // 1 store, 0 load
    logic [ADDR_W-1:0] addr;    // byte address
    logic [DATA_W-1:0] wdata;   // store data
    logic              ack;     // one-cycle completion
    logic [DATA_W-1:0] rdata;   // load data, valid with ack

    // requester side
    modport master (
        output valid,
        output write,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    // responder side
    modport slave (
        input  valid,
        input  write,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // datapath widths
    localparam int DATA_W      = 32;                    // data word
    localparam int ADDR_W      = 32;                    // byte address

    // data RAM geometry
    localparam int RAM_IDX_W   = 14;                    // word index bits
    localparam int RAM_DEPTH   = 2 ** RAM_IDX_W;        // 16K words
    localparam int WORD_LSB    = 2;                     // byte offset bits dropped from index

    // IO page sits at the very top of the map, 0xFFFFFC00 and up
    localparam int IO_PAGE_LSB = 10;                    // lowest bit of the page field
    localparam int IO_PAGE_W   = ADDR_W - IO_PAGE_LSB;  // 22 page bits
    localparam logic [IO_PAGE_W-1:0] IO_PAGE_HI = '1;   // all ones marks IO

    // device select inside the IO page
    localparam int IO_TYPE_BIT = 4;                     // 0 keypad (0x60), 1 vga (0x70)

    // serial loader word address, top bit picks data vs instruction memory
    localparam int LOAD_ADDR_W = RAM_IDX_W + 1;

    // true when the byte address falls in the IO page
    function automatic logic is_io_addr(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:IO_PAGE_LSB] == IO_PAGE_HI;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/mem_stage_top.sv ====
`default_nettype none

module mem_stage_top (
    input  logic                            clk,
    input  logic                            rst_n,
    // pipeline side
    input  logic                            req_valid,
    input  logic                            req_write,
    input  logic [mem_pkg::ADDR_W-1:0]      req_addr,
    input  logic [mem_pkg::DATA_W-1:0]      req_wdata,
    output logic                            stall,
    output logic                            rsp_valid,
    output logic [mem_pkg::DATA_W-1:0]      rsp_data,
    // keypad
    output logic                            key_request,
    input  logic                            key_valid,
    input  logic [mem_pkg::DATA_W-1:0]      key_data,
    // vga
    output logic [mem_pkg::DATA_W-1:0]      vga_value,
    output logic                            vga_update,
    // serial loader
    input  logic                            load_mode,
    input  logic                            load_we,
    input  logic [mem_pkg::LOAD_ADDR_W-1:0] load_addr,
    input  logic [mem_pkg::DATA_W-1:0]      load_data
);

    mem_bus_if ram_bus ();   // decoder to RAM
    mem_bus_if io_bus ();    // decoder to IO page

    data_mem u_data_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_mode (load_mode),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .stall     (stall),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .ram_bus   (ram_bus.master),
        .io_bus    (io_bus.master)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_mode (load_mode),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .bus       (ram_bus.slave)
    );

    io_unit u_io_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_valid   (key_valid),
        .key_data    (key_data),
        .key_request (key_request),
        .vga_value   (vga_value),
        .vga_update  (vga_update),
        .bus         (io_bus.slave)
    );

endmodule

`default_nettype wire
